/* verilog.f */
design/kin_pkg.sv
design/trig_table.sv
design/dh_transform.sv
design/mat_chain.sv
design/full_mat.sv
design/axil_regs.sv
design/kin_top.sv
tb/kin_assert.sv
tb/tb_kin_top.sv

/* Bender.yml */
package:
  name: kin_engine

sources:
  - files:
      - design/kin_pkg.sv
      - design/trig_table.sv
      - design/dh_transform.sv
      - design/mat_chain.sv
      - design/full_mat.sv
      - design/axil_regs.sv
      - design/kin_top.sv
  - target: test
    files:
      - tb/kin_assert.sv
      - tb/tb_kin_top.sv

/* tb/tb_kin_top.sv */
// testbench for the forward-kinematics engine
// AXI4-Lite tasks with stalls, fixed-point reference model
// directed, random and busy-write runs
`timescale 1ns/100ps

module tb_kin_top;
	import kin_pkg::*;

	localparam int  RUNS       = 40;
	localparam int  RUN_CYCLES = 1500; // 24 writes, status polls, 96 reads, stalls included
	localparam real PI         = 3.14159265358979;

	logic                  i, rst;
	logic [AXI_ADDR_W-1:0] awaddr, araddr;
	logic [AXI_DATA_W-1:0] wdata, rdata, rd;
	logic                  awvalid, awready, wvalid, wready, bvalid, bready;
	logic                  arvalid, arready, rvalid, rready;
	logic [1:0]            bresp, rresp;

	int     errors, done_seen, max_stall, cycles;
	bit     timed_out = 1'b0;
	int     p_theta [N_JOINTS], p_d [N_JOINTS], p_a [N_JOINTS], p_alpha [N_JOINTS];
	longint exp_f [N_JOINTS][16];

	kin_top u_dut (
		.i (i), .rst (rst),
		.awaddr (awaddr), .awvalid (awvalid), .awready (awready),
		.wdata (wdata), .wvalid (wvalid), .wready (wready),
		.bresp (bresp), .bvalid (bvalid), .bready (bready),
		.araddr (araddr), .arvalid (arvalid), .arready (arready),
		.rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready)
	);

	initial begin
		i = 1'b0;
		forever #5 i = ~i;
	end

	initial begin
		cycles = 0;
		while (cycles < RUNS * RUN_CYCLES) begin
			@(posedge i);
			cycles++;
		end
		$display("timeout: engine or bus stopped responding after %0d cycles", cycles);
		timed_out = 1'b1;
		finish_run();
	end

	always @(posedge i)
		if (u_dut.done_pulse)
			done_seen++;

	function automatic longint wrap_word(longint v);
		logic signed [WORD_W-1:0] t;
		t = v[WORD_W-1:0];
		return longint'(t);
	endfunction

	function automatic longint fx_mul(longint x, longint y);
		return wrap_word((x * y) >>> FRAC_BITS);
	endfunction

	// sin(2*pi*k/256) * 8192 to nearest
	function automatic longint quarter_sin(int k);
		real v;
		v = $sin(2.0 * PI * k / 256.0) * 8192.0;
		return longint'($floor(v + 0.5));
	endfunction

	function automatic longint sin_idx(int n);
		int m;
		m = n % 256;
		if (m <= 64)
			return quarter_sin(m);
		else if (m <= 128)
			return quarter_sin(128 - m);
		else if (m <= 192)
			return -quarter_sin(m - 128);
		return -quarter_sin(256 - m);
	endfunction

	task automatic model_frames();
		longint link [16];
		longint st, ct, sa, ca, acc;
		for (int j = 0; j < N_JOINTS; j++) begin
			st = sin_idx(p_theta[j]);
			ct = sin_idx(p_theta[j] + 64); // cos is sin a quarter turn on
			sa = sin_idx(p_alpha[j]);
			ca = sin_idx(p_alpha[j] + 64);
			link = '{ct, -fx_mul(st, ca), fx_mul(st, sa), fx_mul(p_a[j], ct),
				st, fx_mul(ct, ca), -fx_mul(ct, sa), fx_mul(p_a[j], st),
				0, sa, ca, p_d[j], 0, 0, 0, 8192};
			for (int k = 0; k < 16; k++) begin
				if (j == 0) begin
					exp_f[0][k] = link[k];
				end else begin
					acc = 0;
					for (int m = 0; m < 4; m++)
						acc += exp_f[j-1][(k / 4) * 4 + m] * link[m * 4 + k % 4];
					exp_f[j][k] = wrap_word(acc >>> FRAC_BITS);
				end
			end
		end
	endtask

	task automatic write_reg(logic [AXI_ADDR_W-1:0] addr, logic [AXI_DATA_W-1:0] data);
		awaddr  <= addr;
		wdata   <= data;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		do @(posedge i); while (!awready);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		repeat ($urandom_range(max_stall, 0)) @(posedge i);
		bready <= 1'b1;
		do @(posedge i); while (!bvalid);
		expect_equal("bresp", 32'h0, bresp);
		bready <= 1'b0;
	endtask

	task automatic read_reg(logic [AXI_ADDR_W-1:0] addr, output logic [AXI_DATA_W-1:0] data);
		araddr  <= addr;
		arvalid <= 1'b1;
		do @(posedge i); while (!arready);
		arvalid <= 1'b0;
		repeat ($urandom_range(max_stall, 0)) @(posedge i);
		rready <= 1'b1;
		do @(posedge i); while (!rvalid);
		data = rdata;
		expect_equal("rresp", 32'h0, rresp);
		rready <= 1'b0;
	endtask

	task automatic expect_equal(string name, logic [31:0] want, logic [31:0] got);
		assert (got === want)
		else begin
			errors++;
			$display("MISMATCH t=%0t %s expected %h got %h", $time, name, want, got);
		end
	endtask

	task automatic check_frames();
		logic [AXI_DATA_W-1:0] got;
		for (int n = 0; n < N_JOINTS * 16; n++) begin
			read_reg(FRAME_BASE + AXI_ADDR_W'(4 * n), got); // 64f + 16r + 4c
			expect_equal($sformatf("frame%0d[%0d][%0d]", n / 16, (n % 16) / 4, n % 4),
				AXI_DATA_W'(exp_f[n / 16][n % 16]), got);
		end
	endtask

	task automatic load_joints();
		for (int j = 0; j < N_JOINTS; j++) begin
			write_reg(DH_BASE + AXI_ADDR_W'(16 * j + 4 * P_THETA), AXI_DATA_W'(p_theta[j]));
			write_reg(DH_BASE + AXI_ADDR_W'(16 * j + 4 * P_D), AXI_DATA_W'(p_d[j]));
			write_reg(DH_BASE + AXI_ADDR_W'(16 * j + 4 * P_A), AXI_DATA_W'(p_a[j]));
			write_reg(DH_BASE + AXI_ADDR_W'(16 * j + 4 * P_ALPHA), AXI_DATA_W'(p_alpha[j]));
		end
	endtask

	task automatic set_joints(bit rnd);
		for (int j = 0; j < N_JOINTS; j++) begin
			p_theta[j] = rnd ? $urandom_range(255, 0) : 0;
			p_alpha[j] = rnd ? $urandom_range(255, 0) : 0;
			p_d[j]     = rnd ? int'($urandom_range(8192, 0)) - 4096 : 0; // within +-0.5
			p_a[j]     = rnd ? int'($urandom_range(8192, 0)) - 4096 : 0;
		end
	endtask

	task automatic wait_done();
		do read_reg(REG_STATUS, rd); while (!rd[1]);
		expect_equal("status at done", 32'h2, rd);
	endtask

	task automatic finish_run();
		$display("errors: %0d compare, %0d assertion, timeout %0d",
			errors, u_dut.u_assert.fail_count, timed_out);
		if (errors == 0 && u_dut.u_assert.fail_count == 0 && !timed_out)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	endtask

	initial begin
		void'($urandom(94));
		rst     <= 1'b1;
		awaddr  <= '0;
		awvalid <= 1'b0;
		wdata   <= '0;
		wvalid  <= 1'b0;
		bready  <= 1'b0;
		araddr  <= '0;
		arvalid <= 1'b0;
		rready  <= 1'b0;
		errors    = 0;
		done_seen = 0;
		max_stall = 3;
		repeat (4) @(posedge i);
		rst <= 1'b0;

		// reset state
		read_reg(REG_STATUS, rd);
		expect_equal("status after reset", 32'h0, rd);
		exp_f = '{default: 0};
		check_frames();

		// zero parameters give identity frames
		set_joints(1'b0);
		load_joints();
		write_reg(REG_CTRL, 32'h1);
		wait_done();
		for (int n = 0; n < N_JOINTS * 16; n++)
			exp_f[n / 16][n % 16] = ((n % 16) % 5 == 0) ? 8192 : 0;
		check_frames();

		// quarter turn on joint 0, link length 1.0
		p_theta[0] = 64;
		p_a[0]     = 8192;
		load_joints();
		write_reg(REG_CTRL, 32'h1);
		wait_done();
		model_frames();
		check_frames();
		read_reg(FRAME_BASE + 12'h15c, rd); // frame 5, row 1, col 3
		expect_equal("frame5 y translation", 32'd8192, rd);

		repeat (30) begin
			set_joints(1'b1);
			load_joints();
			write_reg(REG_CTRL, 32'h1);
			wait_done();
			model_frames();
			check_frames();
		end

		// start and DH writes while busy are dropped
		set_joints(1'b1);
		load_joints();
		model_frames();
		done_seen = 0;
		write_reg(REG_CTRL, 32'h1);
		write_reg(REG_CTRL, 32'h1);
		write_reg(DH_BASE + AXI_ADDR_W'(16 * 5 + 4 * P_THETA),
			AXI_DATA_W'((p_theta[5] + 1) % 256));
		read_reg(REG_STATUS, rd);
		expect_equal("status while busy", 32'h1, rd);
		read_reg(DH_BASE + AXI_ADDR_W'(16 * 5 + 4 * P_THETA), rd);
		expect_equal("joint5 theta", AXI_DATA_W'(p_theta[5]), rd);
		wait_done();
		repeat (120) @(posedge i); // room for a second run, if one had started
		read_reg(REG_STATUS, rd);
		expect_equal("status after idle", 32'h2, rd);
		assert (done_seen == 1)
		else begin
			errors++;
			$display("done pulsed %0d times for a single start", done_seen);
		end
		check_frames();

		// long response stalls
		max_stall = 12;
		set_joints(1'b1);
		load_joints();
		write_reg(REG_CTRL, 32'h1);
		wait_done();
		model_frames();
		check_frames();

		finish_run();
	end

endmodule

/* tb/kin_assert.sv */
// AXI4-Lite response and sequencing assertions
// bound into kin_top, failure count read by the testbench
`timescale 1ns/100ps

module kin_assert (
	input logic                           i,
	input logic                           rst,
	input logic                           awvalid,
	input logic                           awready,
	input logic                           wvalid,
	input logic                           wready,
	input logic                           bvalid,
	input logic                           bready,
	input logic                           rvalid,
	input logic                           rready,
	input logic [kin_pkg::AXI_DATA_W-1:0] rdata,
	input logic                           busy,
	input logic                           done_pulse
);
	int fail_count = 0;

	assert property (@(posedge i) $fell(rst) |-> !busy && !bvalid && !rvalid && !awready)
	else begin
		$error("busy or a valid is high right after reset");
		fail_count++;
	end

	assert property (@(posedge i) disable iff (rst) bvalid && !bready |=> bvalid)
	else begin
		$error("bvalid dropped before bready");
		fail_count++;
	end

	assert property (@(posedge i) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata))
	else begin
		$error("rvalid dropped or rdata changed before rready");
		fail_count++;
	end

	// one response per handshake
	assert property (@(posedge i) disable iff (rst)
		(bvalid && bready) || (rvalid && rready) |=> !(bvalid && $past(bvalid && bready)) &&
			!(rvalid && $past(rvalid && rready)))
	else begin
		$error("response repeated after its handshake");
		fail_count++;
	end

	assert property (@(posedge i) disable iff (rst) awready |-> awvalid && wvalid && wready)
	else begin
		$error("awready high without awvalid and wvalid");
		fail_count++;
	end

	assert property (@(posedge i) disable iff (rst) done_pulse |-> busy ##1 (!busy && !done_pulse))
	else begin
		$error("done_pulse longer than one cycle or busy did not fall with it");
		fail_count++;
	end

	assert property (@(posedge i) disable iff (rst) busy && !done_pulse |=> busy)
	else begin
		$error("busy fell without done_pulse");
		fail_count++;
	end

endmodule

bind kin_top kin_assert u_assert (
	.i (i), .rst (rst),
	.awvalid (awvalid), .awready (awready), .wvalid (wvalid), .wready (wready),
	.bvalid (bvalid), .bready (bready), .rvalid (rvalid), .rready (rready),
	.rdata (rdata), .busy (busy), .done_pulse (done_pulse)
);

/* design/kin_top.sv */
// forward-kinematics engine top
// register slave and joint sequencer
`timescale 1ns/100ps

module kin_top (
	input  logic                           i,
	input  logic                           rst,
	input  logic [kin_pkg::AXI_ADDR_W-1:0] awaddr,
	input  logic                           awvalid,
	output logic                           awready,
	input  logic [kin_pkg::AXI_DATA_W-1:0] wdata,
	input  logic                           wvalid,
	output logic                           wready,
	output logic [1:0]                     bresp,
	output logic                           bvalid,
	input  logic                           bready,
	input  logic [kin_pkg::AXI_ADDR_W-1:0] araddr,
	input  logic                           arvalid,
	output logic                           arready,
	output logic [kin_pkg::AXI_DATA_W-1:0] rdata,
	output logic [1:0]                     rresp,
	output logic                           rvalid,
	input  logic                           rready
);
	import kin_pkg::*;

	logic                                 start, busy, done_pulse;
	logic [N_JOINTS-1:0][3:0][WORD_W-1:0] dh_param;
	logic [JOINT_W-1:0]                   frame_sel;
	logic [1:0]                           row_sel, col_sel;
	logic [WORD_W-1:0]                    frame_elem;

	axil_regs u_regs (
		.i (i), .rst (rst),
		.awaddr (awaddr), .awvalid (awvalid), .awready (awready),
		.wdata (wdata), .wvalid (wvalid), .wready (wready),
		.bresp (bresp), .bvalid (bvalid), .bready (bready),
		.araddr (araddr), .arvalid (arvalid), .arready (arready),
		.rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
		.start (start), .dh_param (dh_param), .busy (busy), .done_pulse (done_pulse),
		.frame_sel (frame_sel), .row_sel (row_sel), .col_sel (col_sel),
		.frame_elem (frame_elem)
	);

	full_mat u_full_mat (
		.i (i), .rst (rst),
		.start (start), .dh_param (dh_param), .busy (busy), .done_pulse (done_pulse),
		.frame_sel (frame_sel), .row_sel (row_sel), .col_sel (col_sel),
		.frame_elem (frame_elem)
	);

endmodule

/* design/axil_regs.sv */
// AXI4-Lite slave with DH parameter file
// control, sticky status and frame readback decode
`timescale 1ns/100ps

module axil_regs (
	input  logic                                                   i,
	input  logic                                                   rst,
	input  logic [kin_pkg::AXI_ADDR_W-1:0]                         awaddr,
	input  logic                                                   awvalid,
	output logic                                                   awready,
	input  logic [kin_pkg::AXI_DATA_W-1:0]                         wdata,
	input  logic                                                   wvalid,
	output logic                                                   wready,
	output logic [1:0]                                             bresp,
	output logic                                                   bvalid,
	input  logic                                                   bready,
	input  logic [kin_pkg::AXI_ADDR_W-1:0]                         araddr,
	input  logic                                                   arvalid,
	output logic                                                   arready,
	output logic [kin_pkg::AXI_DATA_W-1:0]                         rdata,
	output logic [1:0]                                             rresp,
	output logic                                                   rvalid,
	input  logic                                                   rready,
	output logic                                                   start,
	output logic [kin_pkg::N_JOINTS-1:0][3:0][kin_pkg::WORD_W-1:0] dh_param,
	input  logic                                                   busy,
	input  logic                                                   done_pulse,
	output logic [kin_pkg::JOINT_W-1:0]                            frame_sel,
	output logic [1:0]                                             row_sel,
	output logic [1:0]                                             col_sel,
	input  logic [kin_pkg::WORD_W-1:0]                             frame_elem
);
	import kin_pkg::*;

	logic                 done;
	logic                 wr_fire, rd_fire;
	logic                 wr_dh, rd_dh, rd_frame;
	logic [3:0]           wr_joint, rd_joint;
	logic [3:0]           rd_frame_idx;
	logic [WORD_W-1:0]    rd_word;
	logic [AXI_DATA_W-1:0] rd_next;

	assign bresp = RESP_OKAY;
	assign rresp = RESP_OKAY;

	// write channel
	assign wr_fire  = awready && awvalid && wvalid;
	assign wr_joint = awaddr[7:4];
	assign wr_dh    = (awaddr[11:8] == DH_BASE[11:8]) && (wr_joint < 4'(N_JOINTS));

	always_ff @(posedge i) begin
		if (rst) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
		end else begin
			awready <= awvalid && wvalid && !bvalid && !awready;
			wready  <= awvalid && wvalid && !bvalid && !awready;
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge i) begin
		if (rst) begin
			start    <= 1'b0;
			done     <= 1'b0;
			dh_param <= '0;
		end else begin
			start <= 1'b0; // one-cycle pulse
			if (done_pulse)
				done <= 1'b1;
			if (wr_fire && !busy && !start) begin
				if (awaddr == REG_CTRL && wdata[0]) begin
					start <= 1'b1;
					done  <= 1'b0;
				end else if (wr_dh) begin
					if (awaddr[3:2] == 2'(P_THETA) || awaddr[3:2] == 2'(P_ALPHA))
						dh_param[wr_joint[JOINT_W-1:0]][awaddr[3:2]] <=
							{{(WORD_W-ANG_W){1'b0}}, wdata[ANG_W-1:0]};
					else
						dh_param[wr_joint[JOINT_W-1:0]][awaddr[3:2]] <= wdata[WORD_W-1:0];
				end
			end
		end
	end

	// read channel
	assign arready      = !rvalid;
	assign rd_fire      = arvalid && arready;
	assign rd_joint     = araddr[7:4];
	assign rd_dh        = (araddr[11:8] == DH_BASE[11:8]) && (rd_joint < 4'(N_JOINTS));
	assign rd_frame_idx = araddr[9:6];
	assign rd_frame     = (araddr[11:10] == FRAME_BASE[11:10]) &&
		(rd_frame_idx < 4'(N_JOINTS));

	assign frame_sel = rd_frame_idx[JOINT_W-1:0];
	assign row_sel   = araddr[5:4];
	assign col_sel   = araddr[3:2];

	always_comb begin
		rd_word = '0;
		if (rd_dh)
			rd_word = dh_param[rd_joint[JOINT_W-1:0]][araddr[3:2]];
		else if (rd_frame)
			rd_word = frame_elem;
	end

	always_comb begin
		if (araddr == REG_STATUS)
			rd_next = {{(AXI_DATA_W-2){1'b0}}, done, busy};
		else
			rd_next = {{(AXI_DATA_W-WORD_W){rd_word[WORD_W-1]}}, rd_word}; // sign-extend
	end

	always_ff @(posedge i) begin
		if (rst)
			rvalid <= 1'b0;
		else if (rd_fire)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge i) begin
		if (rd_fire)
			rdata <= rd_next;
	end

endmodule

/* design/full_mat.sv */
// joint sequencer and frame store
// link transform per joint, chained through the shared multiplier
`timescale 1ns/100ps

module full_mat (
	input  logic                                                   i,
	input  logic                                                   rst,
	input  logic                                                   start,
	input  logic [kin_pkg::N_JOINTS-1:0][3:0][kin_pkg::WORD_W-1:0] dh_param,
	output logic                                                   busy,
	output logic                                                   done_pulse,
	input  logic [kin_pkg::JOINT_W-1:0]                            frame_sel,
	input  logic [1:0]                                             row_sel,
	input  logic [1:0]                                             col_sel,
	output logic [kin_pkg::WORD_W-1:0]                             frame_elem
);
	import kin_pkg::*;

	typedef enum logic [1:0] {IDLE, LINK, CHAIN} phase_t;

	phase_t                   phase;
	logic [JOINT_W-1:0]       joint, next_joint;
	logic                     load, advance, link_done, chain_last;
	logic                     link_req;
	logic [ANG_W-1:0]         theta, alpha;
	logic signed [WORD_W-1:0] d, a;
	logic [15:0][WORD_W-1:0]  link_mat;
	logic                     link_valid;
	logic                     mul_start;
	logic [WORD_W-1:0]        elem;
	logic [1:0]               elem_row, elem_col;
	logic                     elem_valid;
	logic [N_JOINTS-1:0][15:0][WORD_W-1:0] frames;

	dh_transform u_dh (
		.i          (i),
		.rst        (rst),
		.link_req   (link_req),
		.theta      (theta),
		.alpha      (alpha),
		.d          (d),
		.a          (a),
		.link_mat   (link_mat),
		.link_valid (link_valid)
	);

	mat_chain u_chain (
		.i          (i),
		.rst        (rst),
		.mul_start  (mul_start),
		.mat_a      (frames[joint - JOINT_W'(1)]), // previous frame
		.mat_b      (link_mat),
		.elem       (elem),
		.elem_row   (elem_row),
		.elem_col   (elem_col),
		.elem_valid (elem_valid)
	);

	assign link_done  = (phase == LINK) && link_valid;
	assign chain_last = (phase == CHAIN) && elem_valid && (elem_row == 2'd3) && (elem_col == 2'd3);
	assign mul_start  = link_done && (joint != '0);
	assign done_pulse = chain_last && (joint == JOINT_W'(N_JOINTS - 1));
	assign advance    = (link_done && joint == '0) || (chain_last && !done_pulse);
	assign load       = ((phase == IDLE) && start) || advance;
	assign next_joint = (phase == IDLE) ? '0 : joint + JOINT_W'(1);
	assign busy       = (phase != IDLE);

	always_ff @(posedge i) begin
		if (rst) begin
			phase    <= IDLE;
			joint    <= '0;
			link_req <= 1'b0;
		end else begin
			link_req <= load;
			if (load) begin
				phase <= LINK;
				joint <= next_joint;
			end else if (mul_start) begin
				phase <= CHAIN;
			end else if (done_pulse) begin
				phase <= IDLE;
			end
		end
	end

	// parameters of the joint being requested
	always_ff @(posedge i) begin
		if (load) begin
			theta <= dh_param[next_joint][P_THETA][ANG_W-1:0];
			d     <= dh_param[next_joint][P_D];
			a     <= dh_param[next_joint][P_A];
			alpha <= dh_param[next_joint][P_ALPHA][ANG_W-1:0];
		end
	end

	always_ff @(posedge i) begin
		if (rst) begin
			frames <= '0;
		end else if (link_done && joint == '0) begin
			frames[0] <= link_mat;
		end else if ((phase == CHAIN) && elem_valid) begin
			frames[joint][{elem_row, elem_col}] <= elem;
		end
	end

	assign frame_elem = (frame_sel < JOINT_W'(N_JOINTS)) ?
		frames[frame_sel][{row_sel, col_sel}] : '0;

endmodule

/* design/mat_chain.sv */
// sequential 4x4 fixed-point matrix product
// one element per cycle in row-major order
`timescale 1ns/100ps

module mat_chain (
	input  logic                             i,
	input  logic                             rst,
	input  logic                             mul_start,
	input  logic [15:0][kin_pkg::WORD_W-1:0] mat_a,
	input  logic [15:0][kin_pkg::WORD_W-1:0] mat_b,
	output logic [kin_pkg::WORD_W-1:0]       elem,
	output logic [1:0]                       elem_row,
	output logic [1:0]                       elem_col,
	output logic                             elem_valid
);
	import kin_pkg::*;

	logic [15:0][WORD_W-1:0]    a_q, b_q;
	logic [3:0]                 cnt;
	logic                       active;
	logic signed [2*WORD_W-1:0] p0, p1, p2, p3;
	logic signed [2*WORD_W+1:0] sum;

	always_ff @(posedge i) begin
		if (mul_start) begin
			a_q <= mat_a;
			b_q <= mat_b;
		end
	end

	always_ff @(posedge i) begin
		if (rst) begin
			active <= 1'b0;
			cnt    <= '0;
		end else if (mul_start) begin
			active <= 1'b1;
			cnt    <= '0;
		end else if (active) begin
			cnt <= cnt + 4'd1;
			if (cnt == 4'd15)
				active <= 1'b0;
		end
	end

	assign elem_row = cnt[3:2];
	assign elem_col = cnt[1:0];

	// row of A times column of B
	assign p0 = $signed(a_q[{elem_row, 2'd0}]) * $signed(b_q[{2'd0, elem_col}]);
	assign p1 = $signed(a_q[{elem_row, 2'd1}]) * $signed(b_q[{2'd1, elem_col}]);
	assign p2 = $signed(a_q[{elem_row, 2'd2}]) * $signed(b_q[{2'd2, elem_col}]);
	assign p3 = $signed(a_q[{elem_row, 2'd3}]) * $signed(b_q[{2'd3, elem_col}]);

	assign sum = (p0 + p1) + (p2 + p3);    // shifted once after the sum

	assign elem       = WORD_W'(sum >>> FRAC_BITS);
	assign elem_valid = active;

endmodule

/* design/dh_transform.sv */
// DH link transform for one joint
// trig lookup cycle, then product cycle
`timescale 1ns/100ps

module dh_transform (
	input  logic                                   i,
	input  logic                                   rst,
	input  logic                                   link_req,
	input  logic [kin_pkg::ANG_W-1:0]              theta,
	input  logic [kin_pkg::ANG_W-1:0]              alpha,
	input  logic signed [kin_pkg::WORD_W-1:0]      d,
	input  logic signed [kin_pkg::WORD_W-1:0]      a,
	output logic [15:0][kin_pkg::WORD_W-1:0]       link_mat,
	output logic                                   link_valid
);
	import kin_pkg::*;

	logic signed [WORD_W-1:0] st, ct, sa, ca;
	logic signed [WORD_W-1:0] d_q, a_q;
	logic                     req_q;
	logic signed [WORD_W-1:0] st_ca, st_sa, ct_ca, ct_sa, a_ct, a_st;

	function automatic logic signed [WORD_W-1:0] fx_mul(
		input logic signed [WORD_W-1:0] x,
		input logic signed [WORD_W-1:0] y
	);
		logic signed [2*WORD_W-1:0] p;
		p = x * y;
		return WORD_W'(p >>> FRAC_BITS);
	endfunction

	trig_table u_trig_theta (
		.i       (i),
		.angle   (theta),
		.sin_val (st),
		.cos_val (ct)
	);

	trig_table u_trig_alpha (
		.i       (i),
		.angle   (alpha),
		.sin_val (sa),
		.cos_val (ca)
	);

	// lengths wait one cycle for the table
	always_ff @(posedge i) begin
		d_q <= d;
		a_q <= a;
	end

	always_ff @(posedge i) begin
		if (rst) begin
			req_q      <= 1'b0;
			link_valid <= 1'b0;
		end else begin
			req_q      <= link_req;
			link_valid <= req_q;
		end
	end

	assign st_ca = fx_mul(st, ca);
	assign st_sa = fx_mul(st, sa);
	assign ct_ca = fx_mul(ct, ca);
	assign ct_sa = fx_mul(ct, sa);
	assign a_ct  = fx_mul(a_q, ct);
	assign a_st  = fx_mul(a_q, st);

	always_ff @(posedge i) begin
		link_mat[0]  <= ct;
		link_mat[1]  <= -st_ca;
		link_mat[2]  <= st_sa;
		link_mat[3]  <= a_ct;
		link_mat[4]  <= st;
		link_mat[5]  <= ct_ca;
		link_mat[6]  <= -ct_sa;
		link_mat[7]  <= a_st;
		link_mat[8]  <= '0;
		link_mat[9]  <= sa;
		link_mat[10] <= ca;
		link_mat[11] <= d_q;
		link_mat[12] <= '0; // bottom row is fixed
		link_mat[13] <= '0;
		link_mat[14] <= '0;
		link_mat[15] <= ONE_FX;
	end

endmodule

/* design/trig_table.sv */
// quarter-wave sine/cosine lookup
// one angle in, registered sine and cosine out
`timescale 1ns/100ps

module trig_table (
	input  logic                              i,
	input  logic [kin_pkg::ANG_W-1:0]         angle,
	output logic signed [kin_pkg::WORD_W-1:0] sin_val,
	output logic signed [kin_pkg::WORD_W-1:0] cos_val
);
	import kin_pkg::*;

	logic [1:0] quad;
	logic [5:0] idx;
	logic [6:0] fwd, rev;
	logic signed [WORD_W-1:0] t_fwd, t_rev;

	// sin(2*pi*k/256) * 8192, k = 0..64
	function automatic logic signed [WORD_W-1:0] qsin(input logic [6:0] k);
		logic [13:0] lut [0:64];
		lut = '{
			0, 201, 402, 603, 803, 1003, 1202, 1401,
			1598, 1795, 1990, 2185, 2378, 2570, 2760, 2948,
			3135, 3320, 3503, 3683, 3862, 4038, 4212, 4383,
			4551, 4717, 4880, 5040, 5197, 5351, 5501, 5649,
			5793, 5933, 6070, 6203, 6333, 6458, 6580, 6698,
			6811, 6921, 7027, 7128, 7225, 7317, 7405, 7489,
			7568, 7643, 7713, 7779, 7839, 7895, 7946, 7993,
			8035, 8071, 8103, 8130, 8153, 8170, 8182, 8190,
			8192
		};
		return WORD_W'(lut[k]);
	endfunction

	assign quad  = angle[7:6];
	assign idx   = angle[5:0];
	assign fwd   = {1'b0, idx};
	assign rev   = 7'd64 - {1'b0, idx};
	assign t_fwd = qsin(fwd);
	assign t_rev = qsin(rev);

	always_ff @(posedge i) begin
		case (quad)
			2'd0: begin
				sin_val <= t_fwd;
				cos_val <= t_rev;
			end
			2'd1: begin
				sin_val <= t_rev;
				cos_val <= -t_fwd;
			end
			2'd2: begin
				sin_val <= -t_fwd;
				cos_val <= -t_rev;
			end
			default: begin
				sin_val <= -t_rev;
				cos_val <= t_fwd;
			end
		endcase
	end

endmodule

/* design/kin_pkg.sv */
// shared widths and fixed-point format
// joint count and AXI4-Lite register map
package kin_pkg;

	localparam int WORD_W    = 18;
	localparam int FRAC_BITS = 13;     // s4.13
	localparam int ANG_W     = 8;      // 256 steps per turn
	localparam int N_JOINTS  = 6;
	localparam int JOINT_W   = 3;

	localparam logic signed [WORD_W-1:0] ONE_FX = 18'sd8192;

	localparam int AXI_ADDR_W = 12;
	localparam int AXI_DATA_W = 32;

	// register map
	localparam logic [AXI_ADDR_W-1:0] REG_CTRL   = 12'h000; // bit0 start
	localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 12'h004; // bit0 busy, bit1 done
	localparam logic [AXI_ADDR_W-1:0] DH_BASE    = 12'h100; // +16j +4p
	localparam logic [AXI_ADDR_W-1:0] FRAME_BASE = 12'h400; // +64f +16r +4c

	// order of the four DH parameters within a joint
	localparam int P_THETA = 0;
	localparam int P_D     = 1;
	localparam int P_A     = 2;
	localparam int P_ALPHA = 3;

	localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage
